// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tcb_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
PASS_MSG = Done: no errors

# sources from the file list, plus the included model
SOURCES := $(shell grep -v '^+' $(FILELIST)) verif/tcb_tb_model.svh

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+verif
hdl/tcb_pkg.sv
hdl/tcb_lib_logsize2byteena.sv
hdl/tcb_mem_byteena.sv
hdl/tcb_mem_top.sv
verif/tcb_tb.sv

// File: hdl/tcb_lib_logsize2byteena.sv
`timescale 1ns/100ps
`default_nettype none

module tcb_lib_logsize2byteena (
  input  logic                 clk,
  input  logic                 reset,
  // subordinate side where the manager connects
  input  logic                 sub_vld,
  input  tcb_pkg::tcb_ls_req_t sub_req,
  output logic                 sub_rdy,
  output tcb_pkg::tcb_rsp_t    sub_rsp,
  // manager side toward the memory
  output logic                 man_vld,
  output tcb_pkg::tcb_be_req_t man_req,
  input  logic                 man_rdy,
  input  tcb_pkg::tcb_rsp_t    man_rsp
);

  import tcb_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////////////////////////

  // request offset and index of last byte
  tcb_off_t req_off;
  tcb_off_t req_lst;
  // converted enables and lane ordered write data
  tcb_byt_t req_byt;
  tcb_dat_t req_wdt;

  // context recorded at transfer for the read one cycle later
  tcb_off_t ctx_off;
  tcb_siz_t ctx_siz;
  tcb_ndn_t ctx_ndn;
  tcb_off_t ctx_lst;
  // gathered read data
  tcb_dat_t rsp_rdt;

  // transfer strobe
  logic     trn;

  // last byte index n-1 for a log size and wrapped for the illegal code
  function automatic tcb_off_t size_last(input tcb_siz_t siz);
    return tcb_off_t'((3'd1 << siz) - 3'd1);
  endfunction: size_last

  //////////////////////////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////////////////////////

  // handshake passes straight through
  assign man_vld = sub_vld;
  assign trn     = sub_vld & sub_rdy;

  assign req_off = sub_req.adr[TCB_BUS_MAX-1:0];
  assign req_lst = size_last(sub_req.siz);

  // enable pattern and write bytes rotated by offset into lanes
  always_comb begin : req_lanes
    tcb_off_t k;
    tcb_off_t src;
    req_byt = '0;
    req_wdt = '0;
    for (int unsigned i = 0; i < TCB_BUS_BYT; i++) begin
      // byte position k of this lane relative to the offset
      k = tcb_off_t'(i) - req_off;
      req_byt[i] = (k <= req_lst);
      // big endian mirrors within the access
      unique case (sub_req.ndn)
        TCB_LITTLE: src = k;
        TCB_BIG:    src = req_lst - k;
        default:    src = k;
      endcase
      req_wdt[8*i +: 8] = sub_req.wdt[8*src +: 8];
    end
  end : req_lanes

  // address and write enable unchanged
  assign man_req = '{
    wen: sub_req.wen,
    adr: sub_req.adr,
    byt: req_byt,
    wdt: req_wdt
  };

  //////////////////////////////////////////////////////////////////////
  // response context
  //////////////////////////////////////////////////////////////////////

  // captured on each transfer and held through stalls
  always_ff @(posedge clk) begin
    if (reset) begin
      ctx_off <= '0;
      ctx_siz <= '0;
      ctx_ndn <= TCB_LITTLE;
    end else if (trn) begin
      ctx_off <= req_off;
      ctx_siz <= sub_req.siz;
      ctx_ndn <= sub_req.ndn;
    end
  end

  assign ctx_lst = size_last(ctx_siz);

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  // gather lanes back into right justified order
  always_comb begin : rsp_lanes
    tcb_off_t src;
    rsp_rdt = '0;
    for (int unsigned i = 0; i < TCB_BUS_BYT; i++) begin
      unique case (ctx_ndn)
        TCB_LITTLE: src = tcb_off_t'(i) + ctx_off;
        TCB_BIG:    src = ctx_lst - tcb_off_t'(i) + ctx_off;
        default:    src = tcb_off_t'(i) + ctx_off;
      endcase
      // upper bytes beyond size are filled too
      rsp_rdt[8*i +: 8] = man_rsp.rdt[8*src +: 8];
    end
  end : rsp_lanes

  // status passes through
  assign sub_rsp = '{
    rdt: rsp_rdt,
    sts: man_rsp.sts
  };

  assign sub_rdy = man_rdy;

  //////////////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////////////

  // illegal size code never requested
  a_siz_legal: assert property (
    @(posedge clk) disable iff (reset)
    sub_vld |-> (sub_req.siz != 2'd3)
  );

  // manager holds the request through a stall
  a_req_stable: assert property (
    @(posedge clk) disable iff (reset)
    (sub_vld && !sub_rdy) |=> $stable(sub_req)
  );

  // every transfer reaches memory with one lane per access byte
  a_byt_count: assert property (
    @(posedge clk) disable iff (reset)
    (man_vld && man_rdy) |-> ($countones(man_req.byt) == (1 << sub_req.siz))
  );

endmodule: tcb_lib_logsize2byteena

`default_nettype wire

// File: hdl/tcb_mem_byteena.sv
`timescale 1ns/100ps
`default_nettype none

module tcb_mem_byteena (
  input  logic                 clk,
  input  logic                 reset,
  // request side
  input  logic                 vld,
  input  tcb_pkg::tcb_be_req_t req,
  input  logic                 busy,
  // handshake and response
  output logic                 rdy,
  output tcb_pkg::tcb_rsp_t    rsp
);

  import tcb_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////////////////////////

  // storage, one bus word per entry
  tcb_dat_t mem [0:TCB_MEM_WORDS-1];

  // transfer strobe
  logic     trn;
  // address beyond memory size
  logic     err;
  // word index from the byte address
  logic [TCB_MEM_AW-1:0] idx;

  // registered response
  tcb_dat_t rsp_rdt;
  logic     rsp_sts;

  //////////////////////////////////////////////////////////////////////
  // handshake and decode
  //////////////////////////////////////////////////////////////////////

  // stall input blocks the handshake
  assign rdy = ~busy;
  assign trn = vld & rdy;

  // range check on the full byte address
  assign err = (req.adr >= tcb_adr_t'(TCB_MEM_BYTES));

  // drop offset bits, upper bits only matter for the range check
  assign idx = req.adr[TCB_BUS_MAX +: TCB_MEM_AW];

  //////////////////////////////////////////////////////////////////////
  // write
  //////////////////////////////////////////////////////////////////////

  // commit at the transfer edge, per lane
  always_ff @(posedge clk) begin
    if (trn && req.wen && !err) begin
      for (int unsigned i = 0; i < TCB_BUS_BYT; i++) begin
        if (req.byt[i]) begin
          mem[idx][8*i +: 8] <= req.wdt[8*i +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read
  //////////////////////////////////////////////////////////////////////

  // one cycle latency, whole word read out
  // on writes the old contents come back, don't care upstream
  always_ff @(posedge clk) begin
    if (trn) begin
      if (err) begin
        // nothing returned from outside the array
        rsp_rdt <= '0;
      end else begin
        rsp_rdt <= mem[idx];
      end
    end
  end

  // status register
  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_sts <= 1'b0;
    end else if (trn) begin
      rsp_sts <= err;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  // holds until the next transfer
  assign rsp = '{
    rdt: rsp_rdt,
    sts: rsp_sts
  };

  //////////////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////////////

  // address fully defined whenever a transfer happens
  a_adr_known: assert property (
    @(posedge clk) disable iff (reset)
    trn |-> !$isunknown(req.adr)
  );

endmodule: tcb_mem_byteena

`default_nettype wire

// File: hdl/tcb_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

module tcb_mem_top (
  input  logic                 clk,
  input  logic                 reset,
  // manager side, log size mode
  input  logic                 vld,
  input  tcb_pkg::tcb_ls_req_t req,
  output logic                 rdy,
  output tcb_pkg::tcb_rsp_t    rsp,
  // memory stall
  input  logic                 busy
);

  import tcb_pkg::*;

  // byte enable bus between adapter and memory
  logic        be_vld;
  tcb_be_req_t be_req;
  logic        be_rdy;
  tcb_rsp_t    be_rsp;

  // log size to byte enable conversion
  tcb_lib_logsize2byteena adapter0 (
    .clk     (clk),
    .reset   (reset),
    .sub_vld (vld),
    .sub_req (req),
    .sub_rdy (rdy),
    .sub_rsp (rsp),
    .man_vld (be_vld),
    .man_req (be_req),
    .man_rdy (be_rdy),
    .man_rsp (be_rsp)
  );

  // byte enable memory
  tcb_mem_byteena mem0 (
    .clk   (clk),
    .reset (reset),
    .vld   (be_vld),
    .req   (be_req),
    .busy  (busy),
    .rdy   (be_rdy),
    .rsp   (be_rsp)
  );

endmodule: tcb_mem_top

`default_nettype wire

// File: hdl/tcb_pkg.sv
`default_nettype none

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////////////////////////

  // data bus width in bytes
  localparam int unsigned TCB_BUS_BYT = 4;
  // log2 of bus width, also offset width
  localparam int unsigned TCB_BUS_MAX = 2;
  // byte address width
  localparam int unsigned TCB_ADR_W = 12;

  //////////////////////////////////////////////////////////////////////
  // memory geometry
  //////////////////////////////////////////////////////////////////////

  // memory size in bytes, addresses at or above are out of range
  localparam int unsigned TCB_MEM_BYTES = 1024;
  // number of bus words in memory
  localparam int unsigned TCB_MEM_WORDS = TCB_MEM_BYTES / TCB_BUS_BYT;
  // word index width
  localparam int unsigned TCB_MEM_AW = $clog2(TCB_MEM_WORDS);

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////

  // byte address
  typedef logic [TCB_ADR_W-1:0] tcb_adr_t;
  // byte offset within a bus word
  typedef logic [TCB_BUS_MAX-1:0] tcb_off_t;
  // log size: 0 byte, 1 half, 2 word, 3 illegal
  typedef logic [1:0] tcb_siz_t;
  // byte enable mask, one bit per lane
  typedef logic [TCB_BUS_BYT-1:0] tcb_byt_t;
  // data word, byte lane i at bits [8*i+:8]
  typedef logic [8*TCB_BUS_BYT-1:0] tcb_dat_t;

  // endianness of a log size access
  typedef enum logic {
    TCB_LITTLE = 1'b0,
    TCB_BIG    = 1'b1
  } tcb_ndn_t;

  //////////////////////////////////////////////////////////////////////
  // bus structures
  //////////////////////////////////////////////////////////////////////

  // log size request, write data right justified
  typedef struct packed {
    // write enable
    logic     wen;
    // endianness
    tcb_ndn_t ndn;
    // log size
    tcb_siz_t siz;
    // byte address
    tcb_adr_t adr;
    // write data
    tcb_dat_t wdt;
  } tcb_ls_req_t;

  // byte enable request, write data in lane order
  typedef struct packed {
    logic     wen;
    tcb_adr_t adr;
    // one enable per byte lane
    tcb_byt_t byt;
    tcb_dat_t wdt;
  } tcb_be_req_t;

  // response, shared by both bus modes
  typedef struct packed {
    // read data
    tcb_dat_t rdt;
    // error status
    logic     sts;
  } tcb_rsp_t;

endpackage: tcb_pkg

`default_nettype wire

// File: verif/tcb_tb_model.svh
`ifndef TCB_TB_MODEL_SVH
`define TCB_TB_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////////////////////////

// expected response of one transfer
typedef struct packed {
  logic     wen;
  logic     sts;
  // read bytes right justified
  tcb_dat_t rdt;
  // bytes worth comparing with 8'hff per byte
  tcb_dat_t msk;
} exp_rsp_t;

// byte image of the memory
logic [7:0] model_mem   [0:TCB_MEM_BYTES-1];
// set once a byte has been written
logic       model_known [0:TCB_MEM_BYTES-1];

// one entry per transfer with the oldest first
exp_rsp_t expected [$];

// apply one transfer and push what the DUT should answer
function automatic void apply_request(input tcb_ls_req_t r);
  exp_rsp_t    e;
  int unsigned n;
  int unsigned off;
  int unsigned base;
  int unsigned lane;
  int unsigned j;
  n    = 32'd1 << r.siz;
  off  = 32'(r.adr[1:0]);
  base = 32'({r.adr[TCB_ADR_W-1:2], 2'b00});
  e.wen = r.wen;
  e.sts = (32'(r.adr) >= TCB_MEM_BYTES);
  e.rdt = '0;
  e.msk = '0;
  for (int unsigned k = 0; k < n; k++) begin
    // lanes wrap inside the same word
    lane = (off + k) % TCB_BUS_BYT;
    // byte position within the access mirrored for big endian
    j = (r.ndn == TCB_BIG) ? (n - 1 - k) : k;
    if (e.sts) begin
      // out of range read comes back as zeros
      if (!r.wen) e.msk[8*j +: 8] = 8'hff;
    end else if (r.wen) begin
      model_mem[base + lane]   = r.wdt[8*j +: 8];
      model_known[base + lane] = 1'b1;
    end else begin
      e.rdt[8*j +: 8] = model_mem[base + lane];
      // never written bytes hold whatever the array powered up with
      if (model_known[base + lane]) e.msk[8*j +: 8] = 8'hff;
    end
  end
  expected.push_back(e);
endfunction

`endif

// File: verif/tcb_tb.sv
`timescale 1ns/100ps
`default_nettype none

module tcb_tb;

  import tcb_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // run parameters
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned HALF_PERIOD  = 4;
  localparam int unsigned CLK_PERIOD   = 2 * HALF_PERIOD;
  localparam int unsigned RESET_CYCLES = 3;
  localparam int unsigned NUM_CYCLES   = 3000;
  // inputs change this long after the rising edge
  localparam int unsigned DRV_DLY      = 1;
  localparam int unsigned WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD;
  localparam int          SEED         = 87132;

  // DUT ports
  logic        clk;
  logic        reset;
  logic        vld;
  tcb_ls_req_t req;
  logic        rdy;
  tcb_rsp_t    rsp;
  logic        busy;

  // random state
  int seed;

  // bookkeeping
  int       errors;
  int       n_trn;
  int       n_stall;
  logic     trn_prev;
  tcb_rsp_t last_rsp;

  `include "tcb_tb_model.svh"

  tcb_mem_top dut0 (
    .clk   (clk),
    .reset (reset),
    .vld   (vld),
    .req   (req),
    .rdy   (rdy),
    .rsp   (rsp),
    .busy  (busy)
  );

  initial clk = 1'b0;
  always #(HALF_PERIOD) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic int unsigned rand_below(input int unsigned lim);
    return $unsigned($random(seed)) % lim;
  endfunction

  // mostly a small hot region so accesses overlap
  function automatic tcb_ls_req_t random_request();
    tcb_ls_req_t r;
    int unsigned pick;
    pick  = rand_below(20);
    r.wen = (rand_below(2) == 1);
    r.ndn = (rand_below(2) == 1) ? TCB_BIG : TCB_LITTLE;
    r.siz = tcb_siz_t'(rand_below(3));
    if (pick < 2) begin
      r.adr = tcb_adr_t'(TCB_MEM_BYTES + rand_below(4096 - TCB_MEM_BYTES));
    end else if (pick < 5) begin
      r.adr = tcb_adr_t'(rand_below(TCB_MEM_BYTES));
    end else begin
      r.adr = tcb_adr_t'(rand_below(64));
    end
    r.wdt = tcb_dat_t'($random(seed));
    return r;
  endfunction

  task automatic wait_edge();
    @(posedge clk);
    #(DRV_DLY);
  endtask

  //////////////////////////////////////////////////////////////////////
  // response checks at mid cycle where everything is settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : check
    exp_rsp_t e;
    if (!reset) begin
      assert (rdy === !busy) else begin
        errors++;
        $display("mismatch at %0t: rdy got %0b expected %0b", $time, rdy, !busy);
      end
      if (trn_prev) begin
        // transfer at the last edge makes a response due now
        if (expected.size() == 0) begin
          errors++;
          $display("error at %0t: response due but no request was recorded", $time);
        end else begin
          e = expected.pop_front();
          assert (rsp.sts === e.sts) else begin
            errors++;
            $display("mismatch at %0t: rsp.sts got %0b expected %0b", $time, rsp.sts, e.sts);
          end
          // write data coming back is don't care
          if (!e.wen) begin
            assert ((rsp.rdt & e.msk) === (e.rdt & e.msk)) else begin
              errors++;
              $display("mismatch at %0t: rsp.rdt got %h expected %h (mask %h)",
                       $time, rsp.rdt & e.msk, e.rdt & e.msk, e.msk);
            end
          end
        end
      end else begin
        // without a transfer the response holds
        assert (rsp === last_rsp) else begin
          errors++;
          $display("mismatch at %0t: rsp got %h expected held %h", $time, rsp, last_rsp);
        end
      end
      if (vld && !rdy) n_stall++;
      // model sees the transfer before the edge commits it
      trn_prev = vld && rdy;
      if (trn_prev) begin
        n_trn++;
        apply_request(req);
      end
    end
    last_rsp = rsp;
  end : check

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic held;
    seed     = SEED;
    errors   = 0;
    n_trn    = 0;
    n_stall  = 0;
    trn_prev = 1'b0;
    reset    = 1'b1;
    vld      = 1'b0;
    req      = '0;
    busy     = 1'b0;
    for (int unsigned a = 0; a < TCB_MEM_BYTES; a++) begin
      model_known[a] = 1'b0;
    end
    repeat (RESET_CYCLES) wait_edge();
    reset = 1'b0;
    @(negedge clk);
    assert (rsp.sts === 1'b0) else begin
      errors++;
      $display("mismatch at %0t: rsp.sts after reset got %0b expected 0", $time, rsp.sts);
    end
    for (int unsigned cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      wait_edge();
      // stalled request stays on the bus unchanged
      held = vld && busy;
      busy = (rand_below(10) < 3);
      if (!held) begin
        vld = (rand_below(4) != 0);
        req = random_request();
      end
    end
    // drain the last response
    wait_edge();
    vld  = 1'b0;
    busy = 1'b0;
    repeat (2) wait_edge();
    assert (expected.size() == 0) else begin
      errors++;
      $display("error: %0d expected responses were never checked", expected.size());
    end
    $display("errors: %0d  transfers: %0d  stalled cycles: %0d", errors, n_trn, n_stall);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end : stimulus

  // hard stop well past the planned run length
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("error: run timed out after %0d ns without finishing", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end : watchdog

endmodule: tcb_tb

`default_nettype wire
